// ==== dv/bridge_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_props (
  input logic sys_clk,
  input logic sys_rst_n,
  input logic rx_valid,
  input logic busy,
  input logic tx_start,
  input logic tx_busy,
  input logic echo_start,
  input logic echo_busy,
  input logic link_accept,
  input logic link_req
);

  // a command is held only after a uart byte or an accepted link frame
  busy_has_cmd: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    $rose(busy) |-> ($past(rx_valid) || link_accept)
  ) else $error("busy rose with no command taken");

  // uart_tx takes a byte only when idle
  tx_start_idle: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    tx_start |-> !tx_busy
  ) else $error("tx_start while tx_busy is high");

  echo_start_idle: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    echo_start |-> !echo_busy
  ) else $error("echo_start while echo_busy is high");

  // accept pulse only answers a pending frame
  accept_has_req: assert property (
    @(posedge sys_clk) disable iff (!sys_rst_n)
    link_accept |-> link_req
  ) else $error("link_accept without link_req");

endmodule

bind cmd_dispatch bridge_props i_bridge_props (
  .sys_clk     (sys_clk),
  .sys_rst_n   (sys_rst_n),
  .rx_valid    (rx_valid),
  .busy        (busy),
  .tx_start    (tx_start),
  .tx_busy     (tx_busy),
  .echo_start  (echo_start),
  .echo_busy   (echo_busy),
  .link_accept (link_accept),
  .link_req    (link_req)
);

`default_nettype wire

// ==== dv/bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_tb;
  import bridge_pkg::*;

  localparam int clk_period_ns    = 100;
  localparam int link_half_clks   = 4;    // strobe low, then high
  localparam int link_period_clks = 2 * link_half_clks;
  localparam int uart_frame_clks  = 10 * uart_clks_per_bit;
  localparam int link_frame_clks  = link_frame_bits * link_period_clks;
  localparam int cmd_wait_clks    = 3 * uart_frame_clks;
  localparam int reply_wait_strobes = 4;
  // 46 uart frames over tests 2, 3, 4 and 6; link send, reply and second send
  localparam int test_len_clks    = 46 * uart_frame_clks + 4 * link_frame_clks;
  localparam int watchdog_ns      = 20 * test_len_clks * clk_period_ns;
  localparam int unsigned rand_seed = 32'h0c66_1980;
  localparam logic [7:0] echo_tag_exp = 8'h11;

  logic                 sys_clk = 1'b0;
  logic                 sys_rst_n;
  logic                 uart_rxd;
  logic                 link_strobe;
  logic                 link_rx_bit;
  bank_array_t          in_pin;
  logic                 uart_txd;
  logic                 link_tx_bit;
  logic                 busy;
  logic                 out_clk;
  logic                 out_rst;
  bank_array_t          out_pin;
  logic [num_banks-1:0] out_oe;

  int                   mismatch_cnt = 0;
  int                   other_cnt = 0;
  int                   k;
  int                   rd;
  logic [7:0]           got;
  logic [7:0]           dat;
  logic [7:0]           r0;
  logic [7:0]           r1;
  logic                 exp_clk;
  logic                 exp_rst;
  logic [num_banks-1:0] exp_oe;
  bank_array_t          prev_pin;

  always #(clk_period_ns / 2) sys_clk = ~sys_clk;

  bridge_top i_bridge_top (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .uart_rxd    (uart_rxd),
    .link_strobe (link_strobe),
    .link_rx_bit (link_rx_bit),
    .in_pin      (in_pin),
    .uart_txd    (uart_txd),
    .link_tx_bit (link_tx_bit),
    .busy        (busy),
    .out_clk     (out_clk),
    .out_rst     (out_rst),
    .out_pin     (out_pin),
    .out_oe      (out_oe)
  );

  task automatic check_val(input string name, input logic [63:0] got_v,
                           input logic [63:0] exp_v);
    assert (got_v === exp_v) else begin
      mismatch_cnt++;
      $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got_v, exp_v);
    end
  endtask

  task automatic report_failure(input string what);
    other_cnt++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // every bank but n keeps its old byte
  task automatic check_banks(input bank_array_t old_pin, input int n,
                             input logic [7:0] wr_dat, input logic wr);
    int j;
    for (j = 0; j < num_banks; j++) begin
      check_val($sformatf("out_pin[%0d]", j), out_pin[j],
                (wr && j == n) ? wr_dat : old_pin[j]);
    end
  endtask

  // 8N1, lsb first, called on a falling edge
  task automatic uart_send(input logic [7:0] data);
    int i;
    uart_rxd = 1'b0;
    repeat (uart_clks_per_bit) @(negedge sys_clk);
    for (i = 0; i < byte_w; i++) begin
      uart_rxd = data[i];
      repeat (uart_clks_per_bit) @(negedge sys_clk);
    end
    uart_rxd = 1'b1;
    repeat (uart_clks_per_bit) @(negedge sys_clk);
  endtask

  task automatic uart_capture(output logic [7:0] data);
    int i;
    int n;
    data = '0;
    n = 0;
    while (uart_txd !== 1'b0 && n < cmd_wait_clks) begin
      @(negedge sys_clk);
      n++;
    end
    if (uart_txd !== 1'b0) begin
      report_failure("no start bit seen on uart_txd");
    end else begin
      repeat (uart_clks_per_bit / 2) @(negedge sys_clk);  // middle of the start bit
      for (i = 0; i < byte_w; i++) begin
        repeat (uart_clks_per_bit) @(negedge sys_clk);
        data[i] = uart_txd;
      end
      repeat (uart_clks_per_bit) @(negedge sys_clk);
      check_val("uart_txd stop bit", uart_txd, 1'b1);
    end
  endtask

  // busy has to rise and then fall again
  task automatic wait_cmd_done();
    int n;
    n = 0;
    while (busy !== 1'b1 && n < cmd_wait_clks) begin
      @(negedge sys_clk);
      n++;
    end
    if (busy !== 1'b1) begin
      report_failure("busy never went high after a command");
    end else begin
      n = 0;
      while (busy !== 1'b0 && n < cmd_wait_clks) begin
        @(negedge sys_clk);
        n++;
      end
      if (busy !== 1'b0) begin
        report_failure("busy stayed high after a command");
      end
    end
  endtask

  task automatic uart_command(input logic [7:0] cmd);
    fork
      uart_send(cmd);
      wait_cmd_done();
    join
  endtask

  // one strobe period, reply bit sampled well after the rise
  task automatic link_cycle(input logic bit_in, output logic bit_out);
    link_rx_bit = bit_in;
    link_strobe = 1'b0;
    repeat (link_half_clks) @(negedge sys_clk);
    link_strobe = 1'b1;
    repeat (link_half_clks) @(negedge sys_clk);
    bit_out = link_tx_bit;
  endtask

  task automatic link_send(input logic [7:0] cmd, input logic [7:0] data);
    logic [16:0] frame;
    logic        unused;
    int          i;
    frame = {data, cmd, 1'b1};
    for (i = 0; i < link_frame_bits; i++) begin
      link_cycle(frame[i], unused);
    end
    link_rx_bit = 1'b0;
  endtask

  task automatic link_capture(output logic [7:0] b0, output logic [7:0] b1);
    logic [15:0] frame;
    logic        s;
    int          i;
    int          n;
    frame = '0;
    s = 1'b0;
    n = 0;
    while (!s && n < reply_wait_strobes) begin
      link_cycle(1'b0, s);
      n++;
    end
    if (!s) begin
      report_failure("no start bit seen in the link reply");
    end else begin
      for (i = 0; i < 16; i++) begin
        link_cycle(1'b0, s);
        frame[i] = s;
      end
      link_cycle(1'b0, s);
      check_val("link_tx_bit trailing bit", s, 1'b0);
    end
    b0 = frame[7:0];
    b1 = frame[15:8];
  endtask

  initial begin
    void'($urandom(rand_seed));
    sys_rst_n   = 1'b0;
    uart_rxd    = 1'b1;
    link_strobe = 1'b0;
    link_rx_bit = 1'b0;
    for (k = 0; k < num_banks; k++) begin
      in_pin[k] = 8'($urandom);
    end
    repeat (4) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    @(negedge sys_clk);

    check_val("busy", busy, 1'b0);
    check_val("out_clk", out_clk, 1'b0);
    check_val("out_rst", out_rst, 1'b0);
    check_val("out_oe", out_oe, '0);
    check_val("uart_txd", uart_txd, 1'b1);
    check_val("link_tx_bit", link_tx_bit, 1'b0);

    // control levels 10..13
    exp_clk = 1'b0;
    exp_rst = 1'b0;
    for (k = 0; k < 4; k++) begin
      uart_command(8'h10 | 8'(k));
      case (k)
        0:       exp_clk = 1'b1;
        1:       exp_clk = 1'b0;
        2:       exp_rst = 1'b1;
        default: exp_rst = 1'b0;
      endcase
      check_val("out_clk", out_clk, exp_clk);
      check_val("out_rst", out_rst, exp_rst);
      check_val("busy", busy, 1'b0);
    end

    // reads back to back, each one waits for the previous reply
    fork
      begin
        for (k = 0; k < num_banks; k++) begin
          uart_send(8'h20 | 8'(k));
        end
      end
      begin
        for (rd = 0; rd < num_banks; rd++) begin
          uart_capture(got);
          check_val($sformatf("uart_txd byte of bank %0d", rd), got, in_pin[rd]);
        end
      end
    join
    check_val("busy", busy, 1'b0);

    exp_oe = '0;
    for (k = 0; k < num_banks; k++) begin
      dat      = 8'($urandom);
      prev_pin = out_pin;
      fork
        begin
          uart_send(8'h30 | 8'(k));
          uart_send(dat);
        end
        wait_cmd_done();
      join
      exp_oe[k] = 1'b1;
      check_banks(prev_pin, k, dat, 1'b1);
      check_val("out_oe", out_oe, exp_oe);
    end
    for (k = 0; k < num_banks; k++) begin
      prev_pin = out_pin;
      uart_command(8'h60 | 8'(k));
      exp_oe[k] = 1'b0;
      check_banks(prev_pin, k, 8'h00, 1'b0);
      check_val("out_oe", out_oe, exp_oe);
    end

    // echo over the side link
    dat = 8'($urandom);
    fork
      begin
        link_send(8'hb0, dat);
        link_capture(r0, r1);
      end
      wait_cmd_done();
    join
    check_val("link reply byte 0", r0, echo_tag_exp);
    check_val("link reply byte 1", r1, dat);
    fork
      link_send(8'h12, 8'($urandom));
      wait_cmd_done();
    join
    check_val("out_rst", out_rst, 1'b1);
    check_val("out_clk", out_clk, 1'b0);

    prev_pin = out_pin;
    uart_command(8'h45);  // group 4 is not decoded
    check_val("uart_txd", uart_txd, 1'b1);
    check_val("out_clk", out_clk, 1'b0);
    check_val("out_rst", out_rst, 1'b1);
    check_val("out_oe", out_oe, exp_oe);
    check_val("out_pin", out_pin, prev_pin);
    uart_command(8'h10);
    check_val("out_clk", out_clk, 1'b1);

    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Error: run did not finish within %0d ns", watchdog_ns);
    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, other_cnt + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module bridge_tb -f sources.f -o bridge_sim

./obj_dir/bridge_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== sources.f ====
verilog/bridge_pkg.sv
verilog/uart_rx.sv
verilog/link_rx.sv
verilog/cmd_dispatch.sv
verilog/uart_tx.sv
verilog/link_tx.sv
verilog/bridge_top.sv
dv/bridge_props.sv
dv/bridge_tb.sv

// ==== verilog/bridge_pkg.sv ====
`default_nettype none

package bridge_pkg;

  // data path sizes
  localparam int byte_w     = 8;
  localparam int num_banks  = 8;
  localparam int bank_idx_w = 3;

  // serial timing
  localparam int uart_clks_per_bit = 16;
  localparam int link_frame_bits   = 17;  // start + cmd + data

  // counter widths and compare points
  localparam int uart_cnt_w = $clog2(uart_clks_per_bit);
  localparam int bit_cnt_w  = $clog2(byte_w);
  localparam int link_cnt_w = $clog2(link_frame_bits + 1);

  localparam logic [uart_cnt_w-1:0] uart_cnt_last = uart_cnt_w'(uart_clks_per_bit - 1);
  localparam logic [uart_cnt_w-1:0] uart_cnt_half = uart_cnt_w'(uart_clks_per_bit / 2 - 1);
  localparam logic [bit_cnt_w-1:0]  bit_cnt_last  = bit_cnt_w'(byte_w - 1);
  localparam logic [link_cnt_w-1:0] link_cmd_last = link_cnt_w'(byte_w);
  localparam logic [link_cnt_w-1:0] link_cnt_last = link_cnt_w'(link_frame_bits - 1);
  localparam logic [link_cnt_w-1:0] link_cnt_full = link_cnt_w'(link_frame_bits);

  // first byte of the echo reply
  localparam logic [byte_w-1:0] link_echo_tag = 8'h11;

  typedef logic [num_banks-1:0][byte_w-1:0] bank_array_t;

  // opcode upper nibble
  typedef enum logic [3:0] {
    grp_none        = 4'h0,
    grp_ctrl        = 4'h1,
    grp_pin_read    = 4'h2,
    grp_pin_write   = 4'h3,
    grp_pin_release = 4'h6,
    grp_link_echo   = 4'hb
  } cmd_group_t;

  // lower nibble inside group 1
  typedef enum logic [3:0] {
    clk_high = 4'h0,
    clk_low  = 4'h1,
    rst_high = 4'h2,
    rst_low  = 4'h3
  } ctrl_op_t;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } serial_state_t;

endpackage

`default_nettype wire

// ==== verilog/bridge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_top (
  input  logic                             sys_clk,
  input  logic                             sys_rst_n,
  input  logic                             uart_rxd,
  input  logic                             link_strobe,
  input  logic                             link_rx_bit,
  input  bridge_pkg::bank_array_t          in_pin,
  output logic                             uart_txd,
  output logic                             link_tx_bit,
  output logic                             busy,
  output logic                             out_clk,
  output logic                             out_rst,
  output bridge_pkg::bank_array_t          out_pin,
  output logic [bridge_pkg::num_banks-1:0] out_oe
);
  import bridge_pkg::*;

  // uart side
  logic              rx_valid;
  logic [byte_w-1:0] rx_byte;
  logic              tx_start;
  logic [byte_w-1:0] tx_byte;
  logic              tx_busy;

  // side link
  logic              strobe_rise;
  logic              link_req;
  logic              link_accept;
  logic [byte_w-1:0] link_cmd;
  logic [byte_w-1:0] link_dat;
  logic              echo_start;
  logic [byte_w-1:0] echo_byte0;
  logic [byte_w-1:0] echo_byte1;
  logic              echo_busy;

  uart_rx i_uart_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte)
  );

  link_rx i_link_rx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .link_strobe (link_strobe),
    .link_rx_bit (link_rx_bit),
    .link_accept (link_accept),
    .strobe_rise (strobe_rise),
    .link_req    (link_req),
    .link_cmd    (link_cmd),
    .link_dat    (link_dat)
  );

  cmd_dispatch i_cmd_dispatch (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .link_req    (link_req),
    .link_cmd    (link_cmd),
    .link_dat    (link_dat),
    .tx_busy     (tx_busy),
    .echo_busy   (echo_busy),
    .in_pin      (in_pin),
    .link_accept (link_accept),
    .busy        (busy),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .echo_start  (echo_start),
    .echo_byte0  (echo_byte0),
    .echo_byte1  (echo_byte1),
    .out_clk     (out_clk),
    .out_rst     (out_rst),
    .out_pin     (out_pin),
    .out_oe      (out_oe)
  );

  uart_tx i_uart_tx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .uart_txd  (uart_txd),
    .tx_busy   (tx_busy)
  );

  link_tx i_link_tx (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .strobe_rise (strobe_rise),  // reply is paced by the host strobe
    .echo_start  (echo_start),
    .echo_byte0  (echo_byte0),
    .echo_byte1  (echo_byte1),
    .link_tx_bit (link_tx_bit),
    .echo_busy   (echo_busy)
  );

endmodule

`default_nettype wire

// ==== verilog/cmd_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmd_dispatch (
  input  logic                             sys_clk,
  input  logic                             sys_rst_n,
  input  logic                             rx_valid,
  input  logic [bridge_pkg::byte_w-1:0]    rx_byte,
  input  logic                             link_req,
  input  logic [bridge_pkg::byte_w-1:0]    link_cmd,
  input  logic [bridge_pkg::byte_w-1:0]    link_dat,
  input  logic                             tx_busy,
  input  logic                             echo_busy,
  input  bridge_pkg::bank_array_t          in_pin,
  output logic                             link_accept,
  output logic                             busy,
  output logic                             tx_start,
  output logic [bridge_pkg::byte_w-1:0]    tx_byte,
  output logic                             echo_start,
  output logic [bridge_pkg::byte_w-1:0]    echo_byte0,
  output logic [bridge_pkg::byte_w-1:0]    echo_byte1,
  output logic                             out_clk,
  output logic                             out_rst,
  output bridge_pkg::bank_array_t          out_pin,
  output logic [bridge_pkg::num_banks-1:0] out_oe
);
  import bridge_pkg::*;

  logic [byte_w-1:0]     cmd_q;
  logic [byte_w-1:0]     link_dat_q;  // data byte of the accepted link frame
  logic                  cmd_valid;
  logic                  cmd_done;
  cmd_group_t            cmd_grp;
  ctrl_op_t              cmd_op;
  logic [bank_idx_w-1:0] bank;
  logic                  bank_ok;
  logic                  exec;
  logic                  take_uart;
  logic                  take_link;
  logic                  do_ctrl;
  logic                  do_read;
  logic                  do_write;
  logic                  do_release;
  logic                  do_echo;
  logic                  finish;

  assign cmd_grp   = cmd_group_t'(cmd_q[byte_w-1 -: 4]);
  assign cmd_op    = ctrl_op_t'(cmd_q[3:0]);
  assign bank      = cmd_q[bank_idx_w-1:0];
  assign bank_ok   = ~cmd_q[3];   // banks 8..f do not exist
  assign exec      = cmd_valid & ~cmd_done;
  assign take_uart = rx_valid & ~cmd_valid;
  assign take_link = link_req & ~cmd_valid & ~rx_valid;  // uart wins a tie
  assign busy      = cmd_valid;

  always_comb begin
    do_ctrl    = 1'b0;
    do_read    = 1'b0;
    do_write   = 1'b0;
    do_release = 1'b0;
    do_echo    = 1'b0;
    finish     = 1'b0;
    if (exec) begin
      case (cmd_grp)
        grp_ctrl: begin
          do_ctrl = 1'b1;
          finish  = 1'b1;
        end
        grp_pin_read: begin
          do_read = bank_ok & ~tx_busy;
          finish  = do_read | ~bank_ok;
        end
        grp_pin_write: begin
          do_write = bank_ok & rx_valid;  // wait for the data byte
          finish   = do_write | ~bank_ok;
        end
        grp_pin_release: begin
          do_release = bank_ok;
          finish     = 1'b1;
        end
        grp_link_echo: begin
          do_echo = (cmd_q[3:0] == 4'h0) & ~echo_busy;
          finish  = do_echo | (cmd_q[3:0] != 4'h0);
        end
        default: finish = 1'b1;  // unknown opcode, no effect
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cmd_valid   <= 1'b0;
      cmd_done    <= 1'b0;
      link_accept <= 1'b0;
      tx_start    <= 1'b0;
      echo_start  <= 1'b0;
      out_clk     <= 1'b0;
      out_rst     <= 1'b0;
      out_oe      <= '0;
    end else begin
      link_accept <= take_link;
      tx_start    <= do_read;
      echo_start  <= do_echo;
      if (take_uart || take_link) begin
        cmd_valid <= 1'b1;
      end
      // done flag holds for one cycle, then the command is dropped
      if (cmd_done) begin
        cmd_valid <= 1'b0;
        cmd_done  <= 1'b0;
      end else if (finish) begin
        cmd_done <= 1'b1;
      end
      if (do_ctrl) begin
        case (cmd_op)
          clk_high: out_clk <= 1'b1;
          clk_low:  out_clk <= 1'b0;
          rst_high: out_rst <= 1'b1;
          rst_low:  out_rst <= 1'b0;
          default:  ;
        endcase
      end
      if (do_write) begin
        out_oe[bank] <= 1'b1;
      end
      if (do_release) begin
        out_oe[bank] <= 1'b0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take_uart) begin
      cmd_q <= rx_byte;
    end else if (take_link) begin
      cmd_q      <= link_cmd;
      link_dat_q <= link_dat;
    end
    if (do_read) begin
      tx_byte <= in_pin[bank];
    end
    if (do_write) begin
      out_pin[bank] <= rx_byte;
    end
    if (do_echo) begin
      echo_byte0 <= link_echo_tag;
      echo_byte1 <= link_dat_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/link_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module link_rx (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic                          link_strobe,
  input  logic                          link_rx_bit,
  input  logic                          link_accept,
  output logic                          strobe_rise,
  output logic                          link_req,
  output logic [bridge_pkg::byte_w-1:0] link_cmd,
  output logic [bridge_pkg::byte_w-1:0] link_dat
);
  import bridge_pkg::*;

  logic                  strobe_meta;
  logic                  strobe_sync;
  logic                  strobe_last;
  logic                  bit_meta;
  logic                  bit_sync;   // same delay as strobe_sync
  logic [link_cnt_w-1:0] bit_cnt;    // 0 while waiting for a start bit
  logic [byte_w-1:0]     cmd_shift;
  logic [byte_w-1:0]     dat_shift;

  assign strobe_rise = strobe_sync & ~strobe_last;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      strobe_meta <= 1'b0;
      strobe_sync <= 1'b0;
      strobe_last <= 1'b0;
      bit_meta    <= 1'b0;
      bit_sync    <= 1'b0;
      bit_cnt     <= '0;
      link_req    <= 1'b0;
    end else begin
      strobe_meta <= link_strobe;
      strobe_sync <= strobe_meta;
      strobe_last <= strobe_sync;
      bit_meta    <= link_rx_bit;
      bit_sync    <= bit_meta;
      if (link_accept) begin
        link_req <= 1'b0;
      end
      if (strobe_rise) begin
        if (bit_cnt == '0) begin
          // hold off while the last pair is still pending
          if (bit_sync && !link_req) begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else if (bit_cnt == link_cnt_last) begin
          bit_cnt  <= '0;
          link_req <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // counts 1..8 carry the command, 9..16 the data
  always_ff @(posedge sys_clk) begin
    if (strobe_rise && bit_cnt != '0) begin
      if (bit_cnt <= link_cmd_last) begin
        cmd_shift <= {bit_sync, cmd_shift[byte_w-1:1]};
      end else begin
        dat_shift <= {bit_sync, dat_shift[byte_w-1:1]};
      end
    end
    if (strobe_rise && bit_cnt == link_cnt_last) begin
      link_cmd <= cmd_shift;
      link_dat <= {bit_sync, dat_shift[byte_w-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/link_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module link_tx (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic                          strobe_rise,
  input  logic                          echo_start,
  input  logic [bridge_pkg::byte_w-1:0] echo_byte0,
  input  logic [bridge_pkg::byte_w-1:0] echo_byte1,
  output logic                          link_tx_bit,
  output logic                          echo_busy
);
  import bridge_pkg::*;

  logic [link_frame_bits-1:0] shift;    // start bit sits at bit 0
  logic [link_cnt_w-1:0]      bit_cnt;
  logic                       step;

  assign step = strobe_rise & echo_busy;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bit_cnt     <= '0;
      link_tx_bit <= 1'b0;
      echo_busy   <= 1'b0;
    end else if (echo_start) begin
      bit_cnt   <= '0;
      echo_busy <= 1'b1;
    end else if (step) begin
      if (bit_cnt == link_cnt_full) begin
        link_tx_bit <= 1'b0;  // trailing zero ends the frame
        echo_busy   <= 1'b0;
      end else begin
        link_tx_bit <= shift[0];
        bit_cnt     <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (echo_start) begin
      shift <= {echo_byte1, echo_byte0, 1'b1};
    end else if (step && bit_cnt != link_cnt_full) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic                          uart_rxd,
  output logic                          rx_valid,
  output logic [bridge_pkg::byte_w-1:0] rx_byte
);
  import bridge_pkg::*;

  logic                  rxd_meta;
  logic                  rxd_sync;
  serial_state_t         state;
  logic [uart_cnt_w-1:0] clk_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [byte_w-1:0]     shift;
  logic                  bit_tick;
  logic                  half_tick;

  assign bit_tick  = (clk_cnt == uart_cnt_last);  // middle of a data or stop bit
  assign half_tick = (clk_cnt == uart_cnt_half);  // middle of the start bit

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      state    <= st_idle;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (!rxd_sync) begin
            state <= st_start;
          end
        end
        st_start: begin
          if (half_tick) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rxd_sync ? st_idle : st_data;  // line back high, false start
          end
        end
        st_data: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_last) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          if (bit_tick) begin
            rx_valid <= rxd_sync;  // drop bytes with a bad stop bit
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge sys_clk) begin
    if (state == st_data && bit_tick) begin
      shift <= {rxd_sync, shift[byte_w-1:1]};
    end
    if (state == st_stop && bit_tick) begin
      rx_byte <= shift;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
  input  logic                          sys_clk,
  input  logic                          sys_rst_n,
  input  logic                          tx_start,
  input  logic [bridge_pkg::byte_w-1:0] tx_byte,
  output logic                          uart_txd,
  output logic                          tx_busy
);
  import bridge_pkg::*;

  serial_state_t         state;
  logic [uart_cnt_w-1:0] clk_cnt;
  logic [bit_cnt_w-1:0]  bit_cnt;
  logic [byte_w-1:0]     shift;
  logic                  bit_tick;

  assign bit_tick = (clk_cnt == uart_cnt_last);  // end of the current bit

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state    <= st_idle;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      uart_txd <= 1'b1;
      tx_busy  <= 1'b0;
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (tx_start) begin
            state    <= st_start;
            tx_busy  <= 1'b1;
            uart_txd <= 1'b0;  // start bit
          end
        end
        st_start: begin
          if (bit_tick) begin
            state    <= st_data;
            bit_cnt  <= '0;
            uart_txd <= shift[0];
          end
        end
        st_data: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_last) begin
              state    <= st_stop;
              uart_txd <= 1'b1;
            end else begin
              uart_txd <= shift[0];
            end
          end
        end
        st_stop: begin
          if (bit_tick) begin
            state   <= st_idle;
            tx_busy <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // shift moves in step with uart_txd
  always_ff @(posedge sys_clk) begin
    if (state == st_idle && tx_start) begin
      shift <= tx_byte;
    end else if (bit_tick && (state == st_start || state == st_data)) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire
